// ==== hdl/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define WORD_SIZE 16
`define NUM_REGS 4
`define RESET_PC 16'h0000

// opcodes sit in inst[15:12].
`define OP_RTYPE 4'd15
`define OP_ADI 4'd4
`define OP_ORI 4'd5
`define OP_LHI 4'd6
`define OP_BEQ 4'd1
`define OP_JMP 4'd9

// function codes in inst[5:0] that only apply to OP_RTYPE.
`define FN_ADD 6'd0
`define FN_SUB 6'd1
`define FN_AND 6'd2
`define FN_ORR 6'd3
`define FN_NOT 6'd4
`define FN_WWD 6'd28
`define FN_HLT 6'd29

`endif

// ==== hdl/cpu_pkg.sv ====
`include "cpu_defs.svh"

package cpu_pkg;

	typedef logic [`WORD_SIZE-1:0] word_t;
	typedef logic [`WORD_SIZE-1:0] inst_t;
	typedef logic [$clog2(`NUM_REGS)-1:0] reg_idx_t;

	typedef enum logic [2:0]
	{
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_ORR,
		ALU_NOT,
		ALU_PASS_B,
		ALU_LHI,
		ALU_NONE
	} alu_op_e;

	typedef enum logic [1:0]
	{
		ST_RESET,
		ST_RUN,
		ST_DRAIN,
		ST_HALTED
	} ctrl_state_e;

	// valid must stay the first field since stage_latch clears the msb on flush.
	typedef struct packed
	{
		logic valid;
		word_t pc;
		inst_t inst;
	} ifid_t;

	typedef struct packed
	{
		logic valid;
		word_t pc;
		word_t a;
		word_t b;
		word_t imm; // branch offset or jump target bits.
		reg_idx_t dest;
		logic reg_write;
		alu_op_e alu_op;
		logic is_branch;
		logic is_jump;
		logic is_wwd;
		logic is_hlt;
	} idex_t;

	typedef struct packed
	{
		logic valid;
		word_t result;
		reg_idx_t dest;
		logic reg_write;
		logic is_wwd;
		logic is_hlt;
	} exwb_t;

endpackage

// ==== hdl/stage_latch.sv ====
module stage_latch #(
	parameter type T = logic
) (
	input logic clk,
	input logic arst_n,
	input logic stall,
	input logic flush,
	input T d,
	output T q
);

	localparam int VALID_BIT = $bits(T) - 1; // valid is the msb of every stage bundle.

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			q <= '0;
		else if (flush)
			q[VALID_BIT] <= 1'b0; // bubble with the payload left as is.
		else if (!stall)
			q <= d;
	end

endmodule

// ==== hdl/decode_unit.sv ====
`include "cpu_defs.svh"

module decode_unit import cpu_pkg::*; (
	input logic clk,
	input logic arst_n,
	input ifid_t ifid,
	input exwb_t wb,
	input reg_idx_t ex_dest,
	input logic ex_write,
	output idex_t idex,
	output logic hazard,
	output logic hlt_seen
);

	word_t regs [`NUM_REGS];
	logic [3:0] opcode;
	logic [5:0] funct;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd;
	word_t rs_val;
	word_t rt_val;
	word_t imm_s;
	word_t imm_z;
	logic wb_write;
	logic use_rs;
	logic use_rt;

	assign opcode = ifid.inst[15:12];
	assign rs = ifid.inst[11:10];
	assign rt = ifid.inst[9:8];
	assign rd = ifid.inst[7:6];
	assign funct = ifid.inst[5:0];
	assign imm_s = {{(`WORD_SIZE-8){ifid.inst[7]}}, ifid.inst[7:0]};
	assign imm_z = {{(`WORD_SIZE-8){1'b0}}, ifid.inst[7:0]};

	assign wb_write = wb.valid && wb.reg_write;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wb_write)
			regs[wb.dest] <= wb.result;
	end

	// write-before-read.
	assign rs_val = (wb_write && wb.dest == rs) ? wb.result : regs[rs];
	assign rt_val = (wb_write && wb.dest == rt) ? wb.result : regs[rt];

	always_comb
	begin
		idex = '0;
		idex.valid = ifid.valid;
		idex.pc = ifid.pc;
		idex.a = rs_val;
		idex.b = rt_val;
		idex.imm = imm_s;
		idex.dest = rt;
		idex.alu_op = ALU_NONE;
		use_rs = 1'b1;
		use_rt = 1'b0;
		case (opcode)
			`OP_RTYPE:
			begin
				idex.dest = rd;
				idex.reg_write = 1'b1;
				use_rt = 1'b1;
				case (funct)
					`FN_ADD: idex.alu_op = ALU_ADD;
					`FN_SUB: idex.alu_op = ALU_SUB;
					`FN_AND: idex.alu_op = ALU_AND;
					`FN_ORR: idex.alu_op = ALU_ORR;
					`FN_NOT:
					begin
						idex.alu_op = ALU_NOT;
						use_rt = 1'b0;
					end
					`FN_WWD:
					begin
						idex.alu_op = ALU_PASS_B;
						idex.b = rs_val; // the port value rides on b.
						idex.reg_write = 1'b0;
						idex.is_wwd = 1'b1;
						use_rt = 1'b0;
					end
					`FN_HLT:
					begin
						idex.reg_write = 1'b0;
						idex.is_hlt = 1'b1;
						use_rs = 1'b0;
						use_rt = 1'b0;
					end
					default:
					begin
						idex.reg_write = 1'b0;
						use_rs = 1'b0;
						use_rt = 1'b0;
					end
				endcase
			end
			`OP_ADI:
			begin
				idex.alu_op = ALU_ADD;
				idex.b = imm_s;
				idex.reg_write = 1'b1;
			end
			`OP_ORI:
			begin
				idex.alu_op = ALU_ORR;
				idex.b = imm_z;
				idex.reg_write = 1'b1;
			end
			`OP_LHI:
			begin
				idex.alu_op = ALU_LHI;
				idex.b = imm_z;
				idex.reg_write = 1'b1;
				use_rs = 1'b0;
			end
			`OP_BEQ:
			begin
				idex.is_branch = 1'b1;
				use_rt = 1'b1;
			end
			`OP_JMP:
			begin
				idex.is_jump = 1'b1;
				idex.imm = {{(`WORD_SIZE-12){1'b0}}, ifid.inst[11:0]};
				use_rs = 1'b0;
			end
			default: use_rs = 1'b0;
		endcase
	end

	// only the producer in execute can still be ahead of the register file.
	assign hazard = ifid.valid && ex_write &&
		((use_rs && ex_dest == rs) || (use_rt && ex_dest == rt));
	assign hlt_seen = ifid.valid && idex.is_hlt;

endmodule

// ==== hdl/exec_unit.sv ====
`include "cpu_defs.svh"

module exec_unit import cpu_pkg::*; (
	input idex_t idex,
	output exwb_t exwb,
	output logic redirect,
	output word_t redirect_pc
);

	localparam int HALF = `WORD_SIZE / 2;

	word_t result;
	logic taken;

	always_comb
	begin
		case (idex.alu_op)
			ALU_ADD: result = idex.a + idex.b;
			ALU_SUB: result = idex.a - idex.b;
			ALU_AND: result = idex.a & idex.b;
			ALU_ORR: result = idex.a | idex.b;
			ALU_NOT: result = ~idex.a;
			ALU_PASS_B: result = idex.b;
			ALU_LHI: result = {idex.b[HALF-1:0], {HALF{1'b0}}};
			default: result = '0;
		endcase
	end

	assign taken = idex.is_jump || (idex.is_branch && idex.a == idex.b);
	assign redirect = idex.valid && taken;

	always_comb
	begin
		if (idex.is_jump)
			redirect_pc = {idex.pc[`WORD_SIZE-1:12], idex.imm[11:0]}; // page-local jump.
		else
			redirect_pc = idex.pc + word_t'(1) + idex.imm;
	end

	always_comb
	begin
		exwb.valid = idex.valid;
		exwb.result = result;
		exwb.dest = idex.dest;
		exwb.reg_write = idex.reg_write;
		exwb.is_wwd = idex.is_wwd;
		exwb.is_hlt = idex.is_hlt;
	end

endmodule

// ==== hdl/core_ctrl.sv ====
module core_ctrl import cpu_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic hazard,
	input logic hlt_seen,
	input logic redirect,
	input logic wb_hlt,
	output logic fetch_en,
	output logic stall_ifid,
	output logic flush,
	output logic halted
);

	ctrl_state_e state;
	ctrl_state_e state_next;
	logic hlt_take;

	// a halt sitting behind a taken branch is on the wrong path.
	assign hlt_take = hlt_seen && !redirect;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= ST_RESET;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			ST_RESET: state_next = ST_RUN;
			ST_RUN:
			begin
				if (hlt_take)
					state_next = ST_DRAIN;
			end
			ST_DRAIN:
			begin
				if (wb_hlt)
					state_next = ST_HALTED;
			end
			default: state_next = ST_HALTED; // only reset leaves.
		endcase
	end

	assign flush = redirect;
	assign stall_ifid = hazard && !flush;
	// stop fetching in the same cycle hlt is decoded.
	assign fetch_en = (state == ST_RUN) && !hlt_take;
	assign halted = (state == ST_HALTED);

endmodule

// ==== hdl/retire_counter.sv ====
module retire_counter import cpu_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic retire,
	output word_t count
);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			count <= '0;
		else if (retire)
			count <= count + word_t'(1); // wraps.
	end

endmodule

// ==== hdl/pipe_core.sv ====
`include "cpu_defs.svh"

module pipe_core import cpu_pkg::*; (
	input logic clk,
	input logic arst_n,
	output word_t inst_addr,
	input inst_t inst_data,
	output word_t output_port,
	output logic output_valid,
	output logic halted,
	output word_t num_inst
);

	word_t pc;
	ifid_t ifid_d;
	ifid_t ifid_q;
	idex_t idex_d;
	idex_t idex_q;
	exwb_t exwb_d;
	exwb_t exwb_q;
	logic fetch_en;
	logic stall_ifid;
	logic flush;
	logic hazard;
	logic hlt_seen;
	logic redirect;
	word_t redirect_pc;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			pc <= `RESET_PC;
		else if (flush)
			pc <= redirect_pc;
		else if (fetch_en && !stall_ifid)
			pc <= pc + word_t'(1);
	end

	assign inst_addr = pc;
	assign ifid_d = '{valid: fetch_en, pc: pc, inst: inst_data};

	stage_latch #(.T(ifid_t)) u_ifid_latch (
		.clk(clk),
		.arst_n(arst_n),
		.stall(stall_ifid),
		.flush(flush),
		.d(ifid_d),
		.q(ifid_q)
	);

	decode_unit u_decode (
		.clk(clk),
		.arst_n(arst_n),
		.ifid(ifid_q),
		.wb(exwb_q),
		.ex_dest(idex_q.dest),
		.ex_write(idex_q.valid && idex_q.reg_write),
		.idex(idex_d),
		.hazard(hazard),
		.hlt_seen(hlt_seen)
	);

	// a decode stall leaves a bubble behind in execute.
	stage_latch #(.T(idex_t)) u_idex_latch (
		.clk(clk),
		.arst_n(arst_n),
		.stall(1'b0),
		.flush(flush || stall_ifid),
		.d(idex_d),
		.q(idex_q)
	);

	exec_unit u_exec (
		.idex(idex_q),
		.exwb(exwb_d),
		.redirect(redirect),
		.redirect_pc(redirect_pc)
	);

	stage_latch #(.T(exwb_t)) u_exwb_latch (
		.clk(clk),
		.arst_n(arst_n),
		.stall(1'b0),
		.flush(1'b0),
		.d(exwb_d),
		.q(exwb_q)
	);

	core_ctrl u_ctrl (
		.clk(clk),
		.arst_n(arst_n),
		.hazard(hazard),
		.hlt_seen(hlt_seen),
		.redirect(redirect),
		.wb_hlt(exwb_q.valid && exwb_q.is_hlt),
		.fetch_en(fetch_en),
		.stall_ifid(stall_ifid),
		.flush(flush),
		.halted(halted)
	);

	retire_counter u_retire (
		.clk(clk),
		.arst_n(arst_n),
		.retire(exwb_q.valid),
		.count(num_inst)
	);

	assign output_port = exwb_q.result;
	assign output_valid = exwb_q.valid && exwb_q.is_wwd;

endmodule

// ==== tests/pipe_core_assert.sv ====
module pipe_core_assert import cpu_pkg::*; (
	input logic clk,
	input logic arst_n,
	input logic flush,
	input ifid_t ifid_q,
	input idex_t idex_q,
	input logic output_valid,
	input logic halted
);

	int unsigned fail_count = 0;

	// nothing reaches the port once the core has stopped.
	a_quiet_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
		halted |-> !output_valid)
	else
	begin
		fail_count++;
		$error("output_valid high while halted");
	end

	a_flush_bubbles: assert property (@(posedge clk) disable iff (!arst_n)
		flush |=> !ifid_q.valid && !idex_q.valid)
	else
	begin
		fail_count++;
		$error("wrong-path instruction loaded as valid during flush");
	end

	a_halt_sticky: assert property (@(posedge clk) disable iff (!arst_n)
		halted |=> halted)
	else
	begin
		fail_count++;
		$error("halted dropped without reset");
	end

endmodule

bind pipe_core pipe_core_assert u_assert (
	.clk(clk),
	.arst_n(arst_n),
	.flush(flush),
	.ifid_q(ifid_q),
	.idex_q(idex_q),
	.output_valid(output_valid),
	.halted(halted)
);

// ==== tests/tb_pipe_core.sv ====
`include "cpu_defs.svh"

module tb_pipe_core import cpu_pkg::*; ();

	localparam int PROG_LEN = 40; // length of the random part ahead of the WWD tail and HLT.
	localparam int MEM_WORDS = 256;
	localparam int NUM_PROGS = 8;
	localparam int TIMEOUT = 2000;

	logic clk;
	logic arst_n;
	word_t inst_addr;
	inst_t inst_data;
	word_t output_port;
	logic output_valid;
	logic halted;
	word_t num_inst;

	inst_t imem [MEM_WORDS];
	word_t exp_wwd [$];
	word_t got_wwd [$];
	word_t exp_count;
	logic capture;
	int tests_run;
	int tests_failed;

	pipe_core u_pipe_core (
		.clk(clk),
		.arst_n(arst_n),
		.inst_addr(inst_addr),
		.inst_data(inst_data),
		.output_port(output_port),
		.output_valid(output_valid),
		.halted(halted),
		.num_inst(num_inst)
	);

	assign inst_data = imem[inst_addr[7:0]]; // combinational read.

	always #10 clk = ~clk;

	always @(negedge clk)
	begin
		if (capture && output_valid)
			got_wwd.push_back(output_port);
	end

	function automatic inst_t rtype(reg_idx_t rs, reg_idx_t rt, reg_idx_t rd, logic [5:0] fn);
		return {`OP_RTYPE, rs, rt, rd, fn};
	endfunction

	// unused words decode as r-type no-ops.
	function automatic inst_t fill_word(logic [7:0] a);
		return {`OP_RTYPE, a[7:2], 2'b11, a[3:0]};
	endfunction

	task automatic gen_program();
		int i;
		int off;
		logic [31:0] r;
		reg_idx_t rs;
		reg_idx_t rt;
		reg_idx_t rd;
		for (int a = 0; a < MEM_WORDS; a++)
			imem[a[7:0]] = fill_word(a[7:0]);
		i = 0;
		while (i < PROG_LEN)
		begin
			r = $urandom;
			rs = r[1:0];
			rt = r[3:2];
			rd = r[5:4];
			case (r[11:8])
				4'd0: imem[i[7:0]] = rtype(rs, rt, rd, `FN_ADD);
				4'd1: imem[i[7:0]] = rtype(rs, rt, rd, `FN_SUB);
				4'd2: imem[i[7:0]] = rtype(rs, rt, rd, `FN_AND);
				4'd3: imem[i[7:0]] = rtype(rs, rt, rd, `FN_ORR);
				4'd4: imem[i[7:0]] = rtype(rs, rt, rd, `FN_NOT);
				4'd6, 4'd12: imem[i[7:0]] = {`OP_ORI, rs, rt, r[23:16]};
				4'd7, 4'd11: imem[i[7:0]] = {`OP_LHI, rs, rt, r[23:16]};
				4'd8, 4'd14: imem[i[7:0]] = rtype(rs, rt, rd, `FN_WWD);
				4'd9, 4'd10:
				begin
					if (i > PROG_LEN - 3)
						imem[i[7:0]] = rtype(rs, rt, rd, `FN_ADD);
					else
					begin
						off = 1 + int'(r[31:16]) % (PROG_LEN - i - 1);
						if (r[8])
							imem[i[7:0]] = {`OP_BEQ, rs, rt, 8'(off)};
						else
							imem[i[7:0]] = {`OP_JMP, 12'(i + 1 + off)};
						i++;
						imem[i[7:0]] = rtype(rd, 2'd0, 2'd0, `FN_WWD); // shadow slot.
					end
				end
				default: imem[i[7:0]] = {`OP_ADI, rs, rt, r[23:16]};
			endcase
			i++;
		end
		for (int t = 0; t < `NUM_REGS; t++)
			imem[8'(PROG_LEN + t)] = rtype(2'(t), 2'd0, 2'd0, `FN_WWD);
		imem[8'(PROG_LEN + `NUM_REGS)] = rtype(2'd0, 2'd0, 2'd0, `FN_HLT);
	endtask

	// in-order ISA model without timing.
	task automatic run_model();
		word_t regs [`NUM_REGS];
		inst_t ins;
		logic [7:0] imm8;
		int pc;
		int next_pc;
		int steps;
		logic done;
		exp_wwd.delete();
		exp_count = '0;
		for (int k = 0; k < `NUM_REGS; k++)
			regs[k[1:0]] = '0;
		pc = 0;
		steps = 0;
		done = 1'b0;
		while (!done && steps < MEM_WORDS)
		begin
			ins = imem[pc[7:0]];
			imm8 = ins[7:0];
			next_pc = pc + 1;
			steps++;
			exp_count = exp_count + 16'd1;
			case (ins[15:12])
				`OP_RTYPE:
					case (ins[5:0])
						`FN_ADD: regs[ins[7:6]] = regs[ins[11:10]] + regs[ins[9:8]];
						`FN_SUB: regs[ins[7:6]] = regs[ins[11:10]] - regs[ins[9:8]];
						`FN_AND: regs[ins[7:6]] = regs[ins[11:10]] & regs[ins[9:8]];
						`FN_ORR: regs[ins[7:6]] = regs[ins[11:10]] | regs[ins[9:8]];
						`FN_NOT: regs[ins[7:6]] = ~regs[ins[11:10]];
						`FN_WWD: exp_wwd.push_back(regs[ins[11:10]]);
						`FN_HLT: done = 1'b1;
						default: ;
					endcase
				`OP_ADI: regs[ins[9:8]] = regs[ins[11:10]] + {{8{imm8[7]}}, imm8};
				`OP_ORI: regs[ins[9:8]] = regs[ins[11:10]] | {8'h00, imm8};
				`OP_LHI: regs[ins[9:8]] = {imm8, 8'h00};
				`OP_BEQ:
				begin
					if (regs[ins[11:10]] == regs[ins[9:8]])
						next_pc = pc + 1 + int'($signed(imm8));
				end
				`OP_JMP: next_pc = int'(ins[11:0]); // programs live in the first page.
				default: ;
			endcase
			pc = next_pc;
		end
	endtask

	task automatic report_test(input int prog, input string name, input logic ok);
		tests_run++;
		if (!ok)
			tests_failed++;
		$display("program %0d %s %s", prog, name, ok ? "pass" : "FAIL");
	endtask

	task automatic run_program(input int prog);
		logic ok;
		int cycles;
		int n;
		@(posedge clk);
		#2 arst_n = 1'b0;
		gen_program();
		run_model();
		ok = 1'b1;
		repeat (5)
		begin
			@(negedge clk);
			if (output_valid !== 1'b0 || halted !== 1'b0 || num_inst !== '0)
			begin
				$display("MISMATCH reset_state expected 0 0 0 actual %b %b %0d",
					output_valid, halted, num_inst);
				ok = 1'b0;
			end
		end
		got_wwd.delete();
		capture = 1'b1;
		@(posedge clk);
		#2 arst_n = 1'b1;
		@(negedge clk);
		if (output_valid !== 1'b0 || halted !== 1'b0 || num_inst !== '0)
		begin
			$display("MISMATCH reset_state expected 0 0 0 actual %b %b %0d",
				output_valid, halted, num_inst);
			ok = 1'b0;
		end
		report_test(prog, "reset_state", ok);

		cycles = 0;
		while (halted !== 1'b1 && cycles < TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		ok = 1'b1;
		if (halted !== 1'b1)
		begin
			$display("program %0d halt: core did not halt within %0d cycles", prog, TIMEOUT);
			ok = 1'b0;
		end
		else
		begin
			repeat (20)
			begin
				@(negedge clk);
				if (halted !== 1'b1 || output_valid !== 1'b0)
				begin
					$display("MISMATCH halt expected halted 1 strobe 0 actual %b %b",
						halted, output_valid);
					ok = 1'b0;
				end
			end
		end
		capture = 1'b0;
		report_test(prog, "halt", ok);

		ok = 1'b1;
		n = (got_wwd.size() < exp_wwd.size()) ? got_wwd.size() : exp_wwd.size();
		for (int k = 0; k < n; k++)
		begin
			if (ok && got_wwd[k] !== exp_wwd[k])
			begin
				$display("MISMATCH wwd_stream item %0d expected %h actual %h",
					k, exp_wwd[k], got_wwd[k]);
				ok = 1'b0;
			end
		end
		report_test(prog, "wwd_stream", ok);

		// a leaked shadow WWD shows up as an extra strobe.
		ok = 1'b1;
		if (got_wwd.size() != exp_wwd.size())
		begin
			$display("MISMATCH control_flow expected %0d strobes actual %0d",
				exp_wwd.size(), got_wwd.size());
			ok = 1'b0;
		end
		report_test(prog, "control_flow", ok);

		ok = 1'b1;
		if (num_inst !== exp_count)
		begin
			$display("MISMATCH retire_count expected %0d actual %0d", exp_count, num_inst);
			ok = 1'b0;
		end
		report_test(prog, "retire_count", ok);
	endtask

	initial
	begin
		void'($urandom(96));
		clk = 1'b0;
		arst_n = 1'b0;
		capture = 1'b0;
		tests_run = 0;
		tests_failed = 0;
		for (int p = 0; p < NUM_PROGS; p++)
			run_program(p);
		$display("tests run %0d, passed %0d, failed %0d",
			tests_run, tests_run - tests_failed, tests_failed);
		if (tests_failed == 0 && u_pipe_core.u_assert.fail_count == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/stage_latch.sv
hdl/decode_unit.sv
hdl/exec_unit.sv
hdl/core_ctrl.sv
hdl/retire_counter.sv
hdl/pipe_core.sv
tests/pipe_core_assert.sv
tests/tb_pipe_core.sv

// ==== Makefile ====
SIM = verilator
FLAGS = --binary --timing --assert
TOP = tb_pipe_core
FILELIST = tb.f
OBJ_DIR = obj_dir
LOG = sim.log
PASS_MSG = Done: no errors

BIN = $(OBJ_DIR)/V$(TOP)
SRCS = $(filter-out +%,$(shell cat $(FILELIST)))
HDRS = $(wildcard hdl/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
